//--- ifu_top.f
+incdir+.
ifu_pkg.sv
ifu_pc_gen.sv
ifu_wb_fetch.sv
ifu_issue.sv
ifu_top.sv
tb_ifu_mem.sv
tb_ifu_top.sv

//--- Bender.yml
package:
  name: ifu_top

sources:
  - include_dirs:
      - .
    files:
      - ifu_pkg.sv
      - ifu_pc_gen.sv
      - ifu_wb_fetch.sv
      - ifu_issue.sv
      - ifu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ifu_mem.sv
      - tb_ifu_top.sv

//--- tb_ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module tb_ifu_top;

   import ifu_pkg::*;

   // memory word is address xor this
   localparam logic [31:0] MEM_HASH = 32'h5ac3_96e1;
   // slave answers this word with err
   localparam pc_t ERR_ADR    = 32'h1c00_0420;
   // redirect targets
   localparam pc_t BR_A       = 32'h1c00_0200;
   localparam pc_t BR_B       = 32'h1c00_0300;
   localparam pc_t BR_C       = 32'h1c00_3000;
   localparam pc_t EENTRY     = 32'h1c00_1000;
   localparam pc_t ERA        = 32'h1c00_2000;
   localparam pc_t MISALIGNED = 32'h1c00_0102;
   localparam int  WAIT_LIMIT = 300;

   logic clock;
   logic rst;
   logic br_taken;
   pc_t br_target;
   logic exu_ifu_except;
   pc_t exu_ifu_eentry;
   logic exu_ifu_ertn_e;
   pc_t exu_ifu_era;
   logic exu_ifu_stall_req;
   logic fdp_dec_valid;
   inst_t fdp_dec_inst;
   pc_t fdp_dec_pc;
   logic fdp_dec_ex;
   exc_code_e fdp_dec_exccode;
   pc_t ifu_exu_pc_e;
   pc_t ifu_exu_pc_w;
   logic wb_cyc;
   logic wb_stb;
   pc_t wb_adr;
   logic [`IFU_GRLEN-1:0] wb_dat;
   logic wb_ack;
   logic wb_err;

   integer seed;
   logic redirect;
   // reference state
   pc_t exp_pc;
   pc_t pc_e_d1;
   pc_t pc_e_d2;
   logic fire_d1;
   logic fire_d2;
   pc_t fire_pc_d1;
   pc_t fire_pc_d2;
   int hit_adef;
   int hit_ibe;

   ifu_top dut0 (.*);

   tb_ifu_mem #(.MEM_HASH(MEM_HASH), .ERR_ADR(ERR_ADR)) u_mem (.*);

   assign redirect = br_taken | exu_ifu_except | exu_ifu_ertn_e;

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   // expected instruction word for an address
   function automatic inst_t mem_word(input pc_t adr);
      return adr ^ MEM_HASH;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   // ============================================================
   // reference model
   // ============================================================

   // next expected decode pc by redirect priority except > ertn > branch
   always @(posedge clock) begin
      if (rst) begin
         exp_pc   <= `IFU_BOOT_PC;
         hit_adef <= 0;
         hit_ibe  <= 0;
      end else if (exu_ifu_except) begin
         exp_pc <= exu_ifu_eentry;
      end else if (exu_ifu_ertn_e) begin
         exp_pc <= exu_ifu_era;
      end else if (br_taken) begin
         exp_pc <= br_target;
      end else if (fdp_dec_valid) begin
         exp_pc <= exp_pc + 32'd4;
         if (fdp_dec_exccode == EXC_ADEF) hit_adef <= hit_adef + 1;
         if (fdp_dec_exccode == EXC_IBE) hit_ibe <= hit_ibe + 1;
      end
      // history for the pc pipeline
      pc_e_d1    <= ifu_exu_pc_e;
      pc_e_d2    <= pc_e_d1;
      fire_d1    <= fdp_dec_valid;
      fire_d2    <= fire_d1;
      fire_pc_d1 <= fdp_dec_pc;
      fire_pc_d2 <= fire_pc_d1;
   end

   // ============================================================
   // checks
   // ============================================================

   a_dec_pc: assert property (@(posedge clock) disable iff (rst)
      fdp_dec_valid |-> (fdp_dec_pc == exp_pc))
      else stop_on_error($sformatf("Fail fdp_dec_pc got %h expected %h",
                                   $sampled(fdp_dec_pc), $sampled(exp_pc)));

   a_dec_inst: assert property (@(posedge clock) disable iff (rst)
      (fdp_dec_valid && fdp_dec_pc[1:0] == 2'b00 && fdp_dec_pc != ERR_ADR)
      |-> (fdp_dec_inst == mem_word(fdp_dec_pc) && !fdp_dec_ex && fdp_dec_exccode == EXC_NONE))
      else stop_on_error($sformatf(
         "Fail fdp_dec_inst got %h expected %h, fdp_dec_ex %h fdp_dec_exccode %h",
         $sampled(fdp_dec_inst), mem_word($sampled(fdp_dec_pc)),
         $sampled(fdp_dec_ex), $sampled(fdp_dec_exccode)));

   a_adef: assert property (@(posedge clock) disable iff (rst)
      (fdp_dec_valid && fdp_dec_pc[1:0] != 2'b00) |-> (fdp_dec_ex && fdp_dec_exccode == EXC_ADEF))
      else stop_on_error($sformatf("Fail fdp_dec_exccode got %h expected %h",
                                   $sampled(fdp_dec_exccode), EXC_ADEF));

   a_ibe: assert property (@(posedge clock) disable iff (rst)
      (fdp_dec_valid && fdp_dec_pc == ERR_ADR) |-> (fdp_dec_ex && fdp_dec_exccode == EXC_IBE))
      else stop_on_error($sformatf("Fail fdp_dec_exccode got %h expected %h",
                                   $sampled(fdp_dec_exccode), EXC_IBE));

   // nothing to decode under stall or redirect
   a_kill: assert property (@(posedge clock) disable iff (rst)
      (exu_ifu_stall_req || redirect) |-> !fdp_dec_valid)
      else stop_on_error("decode got a word during stall or redirect");

   a_pc_w: assert property (@(posedge clock) disable iff (rst)
      ifu_exu_pc_w == pc_e_d2)
      else stop_on_error($sformatf("Fail ifu_exu_pc_w got %h expected %h",
                                   $sampled(ifu_exu_pc_w), $sampled(pc_e_d2)));

   a_pc_e: assert property (@(posedge clock) disable iff (rst)
      (fire_d2 && !fire_d1) |-> (ifu_exu_pc_e == fire_pc_d2))
      else stop_on_error($sformatf("Fail ifu_exu_pc_e got %h expected %h",
                                   $sampled(ifu_exu_pc_e), $sampled(fire_pc_d2)));

   // bus idle and decode quiet out of reset
   a_reset: assert property (@(posedge clock)
      rst |=> (!wb_cyc && !fdp_dec_valid))
      else stop_on_error("bus or decode active during reset");

   // wishbone classic protocol
   a_stb_cyc: assert property (@(posedge clock) disable iff (rst)
      wb_stb |-> wb_cyc)
      else stop_on_error("wb_stb high without wb_cyc");

   a_bus_hold: assert property (@(posedge clock) disable iff (rst)
      (wb_cyc && !wb_ack && !wb_err) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
      else stop_on_error("bus cycle dropped or address moved before termination");

   a_bus_drop: assert property (@(posedge clock) disable iff (rst)
      (wb_cyc && (wb_ack || wb_err)) |=> !wb_cyc)
      else stop_on_error("master kept wb_cyc after termination");

   // misaligned pc never reaches the bus
   a_bus_aligned: assert property (@(posedge clock) disable iff (rst)
      wb_cyc |-> (wb_adr[1:0] == 2'b00))
      else stop_on_error($sformatf("Fail wb_adr got %h expected a word address",
                                   $sampled(wb_adr)));

   // ============================================================
   // stimulus
   // ============================================================

   task automatic wait_fires(input int count);
      int seen;
      int cycles;
      seen   = 0;
      cycles = 0;
      while (seen < count) begin
         @(posedge clock);
         if (fdp_dec_valid) seen++;
         cycles++;
         if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for words at decode");
      end
   endtask

   // returns on an edge with a bus cycle still waiting
   task automatic wait_bus_busy();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clock);
         cycles++;
         if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for a bus cycle");
      end while (!(wb_cyc && !wb_ack && !wb_err));
   endtask

   // one cycle redirect request
   task automatic pulse_redirect(input logic exc, input logic ertn, input logic br,
                                 input pc_t target);
      exu_ifu_except <= exc;
      exu_ifu_eentry <= EENTRY;
      exu_ifu_ertn_e <= ertn;
      exu_ifu_era    <= ERA;
      br_taken       <= br;
      br_target      <= target;
      @(posedge clock);
      exu_ifu_except <= 1'b0;
      exu_ifu_ertn_e <= 1'b0;
      br_taken       <= 1'b0;
   endtask

   // random stall and release windows
   task automatic run_stall_windows(input int windows);
      int len;
      for (int w = 0; w < windows; w++) begin
         len = ($random(seed) & 7) + 1;
         exu_ifu_stall_req <= 1'b1;
         repeat (len) @(posedge clock);
         len = ($random(seed) & 3) + 1;
         exu_ifu_stall_req <= 1'b0;
         repeat (len) @(posedge clock);
      end
   endtask

   initial begin
      seed              = 32'h4581;
      rst               = 1'b1;
      br_taken          = 1'b0;
      br_target         = '0;
      exu_ifu_except    = 1'b0;
      exu_ifu_eentry    = '0;
      exu_ifu_ertn_e    = 1'b0;
      exu_ifu_era       = '0;
      exu_ifu_stall_req = 1'b0;
      repeat (10) @(posedge clock);
      rst <= 1'b0;

      // sequential stream from the boot pc
      wait_fires(12);
      pulse_redirect(1'b0, 1'b0, 1'b1, BR_A);
      wait_fires(6);
      // redirect with a bus cycle in flight
      wait_bus_busy();
      pulse_redirect(1'b0, 1'b0, 1'b1, BR_B);
      wait_fires(4);
      // all three at once and then ertn against branch
      pulse_redirect(1'b1, 1'b1, 1'b1, BR_C);
      wait_fires(4);
      pulse_redirect(1'b0, 1'b1, 1'b1, BR_C);
      wait_fires(4);
      run_stall_windows(8);
      wait_fires(4);
      // branch while stalled
      exu_ifu_stall_req <= 1'b1;
      repeat (3) @(posedge clock);
      pulse_redirect(1'b0, 1'b0, 1'b1, BR_A);
      exu_ifu_stall_req <= 1'b0;
      wait_fires(3);
      // fetch exceptions
      pulse_redirect(1'b0, 1'b0, 1'b1, MISALIGNED);
      wait_fires(3);
      pulse_redirect(1'b0, 1'b0, 1'b1, ERR_ADR - 32'd8);
      wait_fires(5);
      repeat (4) @(posedge clock);

      if (hit_adef > 0 && hit_ibe > 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         stop_on_error("fetch exception words never reached decode");
      end
   end

endmodule

`default_nettype wire

//--- tb_ifu_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module tb_ifu_mem #(
   parameter logic [`IFU_GRLEN-1:0] MEM_HASH = '0,
   parameter logic [`IFU_GRLEN-1:0] ERR_ADR  = '0
) (
   input  wire                      clock,
   input  wire                      rst,
   // wishbone classic slave side
   input  wire                      wb_cyc,
   input  wire                      wb_stb,
   input  wire ifu_pkg::pc_t        wb_adr,
   output logic [`IFU_GRLEN-1:0]    wb_dat,
   output logic                     wb_ack,
   output logic                     wb_err
);

   import ifu_pkg::*;

   integer   seed;
   int       wait_cnt;

   // own random stream from the common seed
   // bus answer quiet from time zero
   initial begin
      seed = 32'h4581;
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      wb_dat <= '0;
   end

   // ============================================================
   // read response with random wait states
   // ============================================================

   always @(posedge clock) begin
      if (rst) begin
         wb_ack   <= 1'b0;
         wb_err   <= 1'b0;
         wb_dat   <= '0;
         wait_cnt <= 0;
      end else begin
         // termination is a single cycle pulse
         wb_ack <= 1'b0;
         wb_err <= 1'b0;
         if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
            if (wait_cnt == 0) begin
               if (wb_adr == ERR_ADR) begin
                  // marked word answers with err and no data
                  wb_err <= 1'b1;
                  wb_dat <= '0;
               end else begin
                  wb_ack <= 1'b1;
                  // memory content computed from the whole address
                  wb_dat <= wb_adr ^ MEM_HASH;
               end
               // 0..3 wait states for the next cycle
               wait_cnt <= $random(seed) & 3;
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module ifu_top (
   input  wire                      clock,
   input  wire                      rst,
   // execute unit requests
   input  wire                      br_taken,
   input  wire ifu_pkg::pc_t        br_target,
   input  wire                      exu_ifu_except,
   input  wire ifu_pkg::pc_t        exu_ifu_eentry,
   input  wire                      exu_ifu_ertn_e,
   input  wire ifu_pkg::pc_t        exu_ifu_era,
   input  wire                      exu_ifu_stall_req,
   // decode
   output logic                     fdp_dec_valid,
   output ifu_pkg::inst_t           fdp_dec_inst,
   output ifu_pkg::pc_t             fdp_dec_pc,
   output logic                     fdp_dec_ex,
   output ifu_pkg::exc_code_e       fdp_dec_exccode,
   // stage pcs back to execute
   output ifu_pkg::pc_t             ifu_exu_pc_e,
   output ifu_pkg::pc_t             ifu_exu_pc_w,
   // wishbone
   output logic                     wb_cyc,
   output logic                     wb_stb,
   output ifu_pkg::pc_t             wb_adr,
   input  wire [`IFU_GRLEN-1:0]     wb_dat,
   input  wire                      wb_ack,
   input  wire                      wb_err
);

   import ifu_pkg::*;

   pc_t       fetch_pc;
   logic      fetch_flush;
   logic      dec_fire;
   logic      rsp_valid;
   inst_t     rsp_inst;
   pc_t       rsp_pc;
   exc_code_e rsp_exc;

   // ============================================================
   // pc generation and bus fetch side by side
   // ============================================================

   ifu_pc_gen u_pc_gen (
      .clock          (clock),
      .rst            (rst),
      .br_taken       (br_taken),
      .br_target      (br_target),
      .exu_ifu_except (exu_ifu_except),
      .exu_ifu_eentry (exu_ifu_eentry),
      .exu_ifu_ertn_e (exu_ifu_ertn_e),
      .exu_ifu_era    (exu_ifu_era),
      .dec_fire       (dec_fire),
      .fetch_pc       (fetch_pc),
      .fetch_flush    (fetch_flush)
   );

   ifu_wb_fetch u_wb_fetch (
      .clock       (clock),
      .rst         (rst),
      .fetch_pc    (fetch_pc),
      .fetch_flush (fetch_flush),
      .dec_fire    (dec_fire),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_adr      (wb_adr),
      .wb_dat      (wb_dat),
      .wb_ack      (wb_ack),
      .wb_err      (wb_err),
      .rsp_valid   (rsp_valid),
      .rsp_inst    (rsp_inst),
      .rsp_pc      (rsp_pc),
      .rsp_exc     (rsp_exc)
   );

   // issue joins both and feeds decode
   ifu_issue u_issue (
      .clock             (clock),
      .rst               (rst),
      .rsp_valid         (rsp_valid),
      .rsp_inst          (rsp_inst),
      .rsp_pc            (rsp_pc),
      .rsp_exc           (rsp_exc),
      .fetch_flush       (fetch_flush),
      .exu_ifu_stall_req (exu_ifu_stall_req),
      .dec_fire          (dec_fire),
      .fdp_dec_valid     (fdp_dec_valid),
      .fdp_dec_inst      (fdp_dec_inst),
      .fdp_dec_pc        (fdp_dec_pc),
      .fdp_dec_ex        (fdp_dec_ex),
      .fdp_dec_exccode   (fdp_dec_exccode),
      .ifu_exu_pc_e      (ifu_exu_pc_e),
      .ifu_exu_pc_w      (ifu_exu_pc_w)
   );

endmodule

`default_nettype wire

//--- ifu_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module ifu_issue (
   input  wire                      clock,
   input  wire                      rst,
   // response buffer
   input  wire                      rsp_valid,
   input  wire ifu_pkg::inst_t      rsp_inst,
   input  wire ifu_pkg::pc_t        rsp_pc,
   input  wire ifu_pkg::exc_code_e  rsp_exc,
   input  wire                      fetch_flush,
   input  wire                      exu_ifu_stall_req,
   output logic                     dec_fire,
   // decode side
   output logic                     fdp_dec_valid,
   output ifu_pkg::inst_t           fdp_dec_inst,
   output ifu_pkg::pc_t             fdp_dec_pc,
   output logic                     fdp_dec_ex,
   output ifu_pkg::exc_code_e       fdp_dec_exccode,
   // pc of later stages for execute
   output ifu_pkg::pc_t             ifu_exu_pc_e,
   output ifu_pkg::pc_t             ifu_exu_pc_w
);

   import ifu_pkg::*;

   // decode, execute, memory, writeback
   pc_t pc_pipe [`IFU_PC_STAGES];

   // ============================================================
   // fire / kill
   // ============================================================

   // stall holds the word, redirect kills it
   assign dec_fire = rsp_valid & ~exu_ifu_stall_req & ~fetch_flush;

   assign fdp_dec_valid   = dec_fire;
   assign fdp_dec_inst    = rsp_inst;
   assign fdp_dec_pc      = rsp_pc;
   assign fdp_dec_exccode = rsp_exc;
   // exception flag only on a real slot
   assign fdp_dec_ex      = dec_fire & (rsp_exc != EXC_NONE);

   // ============================================================
   // pc pipeline
   // ============================================================

   // decode stage loads on fire, later stages shift each cycle
   always_ff @(posedge clock) begin
      if (rst) begin
         for (int i = 0; i < `IFU_PC_STAGES; i++) begin
            pc_pipe[i] <= '0;
         end
      end else begin
         if (dec_fire) begin
            pc_pipe[0] <= fdp_dec_pc;
         end
         for (int i = 1; i < `IFU_PC_STAGES; i++) begin
            pc_pipe[i] <= pc_pipe[i-1];
         end
      end
   end

   assign ifu_exu_pc_e = pc_pipe[1];
   // writeback is the last stage
   assign ifu_exu_pc_w = pc_pipe[`IFU_PC_STAGES-1];

   // ============================================================
   // checks
   // ============================================================

   // nothing reaches decode under stall or redirect
   a_kill: assert property (
      @(posedge clock) disable iff (rst)
      (exu_ifu_stall_req || fetch_flush) |-> !fdp_dec_valid
   );

   // stalled word still in the fetch buffer next cycle, same pc
   a_stall_hold: assert property (
      @(posedge clock) disable iff (rst)
      (rsp_valid && exu_ifu_stall_req && !fetch_flush) |=> (rsp_valid && $stable(rsp_pc))
   );

endmodule

`default_nettype wire

//--- ifu_wb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module ifu_wb_fetch (
   input  wire                      clock,
   input  wire                      rst,
   input  wire ifu_pkg::pc_t        fetch_pc,
   input  wire                      fetch_flush,
   input  wire                      dec_fire,
   // wishbone classic read master
   output logic                     wb_cyc,
   output logic                     wb_stb,
   output ifu_pkg::pc_t             wb_adr,
   input  wire [`IFU_GRLEN-1:0]     wb_dat,
   input  wire                      wb_ack,
   input  wire                      wb_err,
   // one-entry response buffer
   output logic                     rsp_valid,
   output ifu_pkg::inst_t           rsp_inst,
   output ifu_pkg::pc_t             rsp_pc,
   output ifu_pkg::exc_code_e       rsp_exc
);

   import ifu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_BUS     = 2'd1,
      ST_DISCARD = 2'd2
   } fetch_state_e;

   fetch_state_e state;
   fetch_state_e state_nxt;
   pc_t          issue_adr;
   logic         term;
   logic         issue;
   logic         misalign;
   logic         start_bus;
   logic         post_adef;
   logic         fill_bus;

   // ============================================================
   // issue decision
   // ============================================================

   // fetch_pc still names the buffered word while it is consumed
   assign issue_adr = dec_fire ? (fetch_pc + pc_t'(4)) : fetch_pc;
   assign misalign  = |issue_adr[1:0];

   // idle bus, room in the buffer, no redirect in progress
   assign issue     = (state == ST_IDLE) & (~rsp_valid | dec_fire) & ~fetch_flush;
   assign start_bus = issue & ~misalign;
   // misaligned pc never reaches the bus
   assign post_adef = issue & misalign;

   // termination of the running cycle
   assign term      = wb_cyc & (wb_ack | wb_err);
   // result kept only when nobody flushed it
   assign fill_bus  = (state == ST_BUS) & term & ~fetch_flush;

   // ============================================================
   // bus fsm
   // ============================================================

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (start_bus) begin
               state_nxt = ST_BUS;
            end
         end
         ST_BUS: begin
            if (term) begin
               state_nxt = ST_IDLE;
            end else if (fetch_flush) begin
               // cycle cannot be cancelled, drop its data later
               state_nxt = ST_DISCARD;
            end
         end
         ST_DISCARD: begin
            if (term) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // address latched at issue, held until termination
   always_ff @(posedge clock) begin
      if (start_bus) begin
         wb_adr <= issue_adr;
      end
   end

   // single read per cycle, strobe follows cyc
   assign wb_cyc = (state != ST_IDLE);
   assign wb_stb = wb_cyc;

   // ============================================================
   // response buffer
   // ============================================================

   always_ff @(posedge clock) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else if (fetch_flush) begin
         rsp_valid <= 1'b0;
      end else if (fill_bus || post_adef) begin
         rsp_valid <= 1'b1;
      end else if (dec_fire) begin
         rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clock) begin
      if (fill_bus) begin
         rsp_pc   <= wb_adr;
         rsp_inst <= wb_err ? '0 : wb_dat[31:0];
         rsp_exc  <= wb_err ? EXC_IBE : EXC_NONE;
      end else if (post_adef) begin
         rsp_pc   <= issue_adr;
         rsp_inst <= '0;
         rsp_exc  <= EXC_ADEF;
      end
   end

   // ============================================================
   // checks
   // ============================================================

   // waiting cycle keeps cyc, stb and address
   a_bus_hold: assert property (
      @(posedge clock) disable iff (rst)
      (wb_cyc && !wb_ack && !wb_err) |=> (wb_stb && wb_cyc && $stable(wb_adr))
   );

   // full buffer not taken by issue blocks a new cycle
   a_no_overrun: assert property (
      @(posedge clock) disable iff (rst)
      (rsp_valid && !dec_fire) |=> !$rose(wb_cyc)
   );

   // bus only ever sees word addresses
   a_aligned: assert property (
      @(posedge clock) disable iff (rst)
      wb_cyc |-> (wb_adr[1:0] == 2'b00)
   );

endmodule

`default_nettype wire

//--- ifu_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifu_settings.svh"

module ifu_pc_gen (
   input  wire              clock,
   input  wire              rst,
   // branch resolved in execute
   input  wire              br_taken,
   input  wire ifu_pkg::pc_t br_target,
   // exception entry
   input  wire              exu_ifu_except,
   input  wire ifu_pkg::pc_t exu_ifu_eentry,
   // exception return
   input  wire              exu_ifu_ertn_e,
   input  wire ifu_pkg::pc_t exu_ifu_era,
   // buffered word taken by decode
   input  wire              dec_fire,
   output ifu_pkg::pc_t     fetch_pc,
   output logic             fetch_flush
);

   import ifu_pkg::*;

   logic redirect;
   logic sel_exc;
   logic sel_ertn;
   logic sel_br;
   logic sel_inc;
   logic sel_hold;
   pc_t  pc_inc;
   pc_t  next_pc;

   // ============================================================
   // redirect decode
   // ============================================================

   // any redirect kills the fetch path this cycle
   assign redirect = exu_ifu_except | exu_ifu_ertn_e | br_taken;

   // except first, then ertn, then branch
   assign sel_exc  = exu_ifu_except;
   assign sel_ertn = exu_ifu_ertn_e & ~exu_ifu_except;
   assign sel_br   = br_taken & ~exu_ifu_ertn_e & ~exu_ifu_except;

   // sequential advance only on a clean fire
   assign sel_inc  = dec_fire & ~redirect;
   // nothing taken, keep pointing at the same word
   assign sel_hold = ~dec_fire & ~redirect;

   // flush pulse follows the request, fetch and issue drop their word
   assign fetch_flush = redirect;

   // ============================================================
   // next pc mux
   // ============================================================

   // low two bits kept, misaligned pc stays misaligned
   assign pc_inc = fetch_pc + pc_t'(4);

   // and-or mux, the five selects are one-hot
   assign next_pc = ({`IFU_GRLEN{sel_exc}}  & exu_ifu_eentry)
                  | ({`IFU_GRLEN{sel_ertn}} & exu_ifu_era)
                  | ({`IFU_GRLEN{sel_br}}   & br_target)
                  | ({`IFU_GRLEN{sel_inc}}  & pc_inc)
                  | ({`IFU_GRLEN{sel_hold}} & fetch_pc);

   // fetch pc register
   always_ff @(posedge clock) begin
      if (rst) begin
         fetch_pc <= pc_t'(`IFU_BOOT_PC);
      end else begin
         fetch_pc <= next_pc;
      end
   end

   // ============================================================
   // checks
   // ============================================================

   // issue never fires a word while a redirect is taken,
   // and only one redirect source drives the mux
   a_one_source: assert property (
      @(posedge clock) disable iff (rst)
      redirect |-> (!dec_fire && $onehot({sel_exc, sel_ertn, sel_br}))
   );

   // pc moves only on fire or redirect
   a_pc_stable: assert property (
      @(posedge clock) disable iff (rst)
      (!dec_fire && !redirect) |=> $stable(fetch_pc)
   );

endmodule

`default_nettype wire

//--- ifu_pkg.sv
`default_nettype none

`include "ifu_settings.svh"

// ============================================================
// shared fetch types
// ============================================================

package ifu_pkg;

   // program counter, same width as a general register
   typedef logic [`IFU_GRLEN-1:0] pc_t;

   // one instruction word
   typedef logic [31:0] inst_t;

   // fetch side exception codes
   // values follow the ecode field of estat
   typedef enum logic [5:0] {
      // no exception on this word
      EXC_NONE = 6'h00,
      // address error on fetch, pc not word aligned
      EXC_ADEF = 6'h08,
      // instruction bus error, slave answered with err
      EXC_IBE  = 6'h2a
   } exc_code_e;

endpackage

`default_nettype wire

//--- ifu_settings.svh
`ifndef IFU_SETTINGS_SVH
`define IFU_SETTINGS_SVH

// ============================================================
// instruction fetch unit build settings
// ============================================================

// general register length, also the pc width
`define IFU_GRLEN 32

// first fetch address out of reset
`define IFU_BOOT_PC 32'h1c000000

// pc pipeline depth behind fetch
// stage 0 is decode, 1 execute, 2 memory, last one writeback
`define IFU_PC_STAGES 4

`endif
